//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_cpu
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the simulation, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/cpu_pkg.sv
// widths, state and step encodings, operand sources, alu ops, opcodes, sfr map, pc union
package cpu_pkg;

    localparam int data_w  = 8;
    localparam int addr_w  = 16;
    localparam int phase_w = 4;

    // one-hot instruction states
    typedef enum logic [6:0] {
        nop_wait   = 7'b000_0001,
        get_ins    = 7'b000_0010,
        ins_decode = 7'b000_0100,
        ram_read   = 7'b000_1000,
        rom_read   = 7'b001_0000,
        process    = 7'b010_0000,
        ram_write  = 7'b100_0000
    } cpu_state_t;

    localparam int nop_wait_idx   = 0;
    localparam int get_ins_idx    = 1;
    localparam int ins_decode_idx = 2;
    localparam int ram_read_idx   = 3;
    localparam int rom_read_idx   = 4;
    localparam int process_idx    = 5;
    localparam int ram_write_idx  = 6;

    typedef enum logic [2:0] {
        to_nop,
        to_ram_read,
        to_rom_read,
        to_process,
        to_ram_write,
        to_get_ins
    } decode_step_t;

    typedef enum logic [3:0] {
        src_a,
        src_ram_reg,
        src_rom_reg,
        src_addr,
        src_pch,
        src_pcl,
        src_none
    } operand_src_t;

    typedef enum logic [2:0] {
        alu_pass_b,
        alu_add,
        alu_subb,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    localparam logic [7:0] op_nop       = 8'h00;
    localparam logic [7:0] op_mov_a_imm = 8'h74;
    localparam logic [7:0] op_mov_a_dir = 8'hE5;
    localparam logic [7:0] op_mov_dir_a = 8'hF5;
    localparam logic [7:0] op_add_imm   = 8'h24;
    localparam logic [7:0] op_add_dir   = 8'h25;
    localparam logic [7:0] op_subb_imm  = 8'h94;
    localparam logic [7:0] op_anl_imm   = 8'h54;
    localparam logic [7:0] op_orl_imm   = 8'h44;
    localparam logic [7:0] op_xrl_imm   = 8'h64;
    localparam logic [7:0] op_ljmp      = 8'h02;

    localparam logic [7:0] sfr_acc = 8'hE0;
    localparam logic [7:0] sfr_psw = 8'hD0;

    localparam int psw_cy = 7;
    localparam int psw_p  = 0;

    localparam logic [2:0] nop_duration = 3'd6; // 7 idle cycles incl. zero

    typedef struct packed {
        logic [7:0] pch;
        logic [7:0] pcl;
    } pc_bytes_t;

    // flat for increment, byte view for ljmp load
    typedef union packed {
        logic [addr_w-1:0] word;
        pc_bytes_t         bytes;
    } pc_word_t;

endpackage

//--- common/decode_if.sv
// decoded control word shared by decoder, control unit and datapath
`timescale 1ns/10ps

interface decode_if import cpu_pkg::*; ();

    logic [data_w-1:0]  opcode;      // from instruction register
    logic [phase_w-1:0] phase;       // steps left, owned by control
    logic [phase_w-1:0] phase_init;  // step count of the opcode
    decode_step_t       next_step;
    operand_src_t       a_src;       // first operand / destination
    operand_src_t       b_src;
    alu_op_t            alu_op;
    logic [data_w-1:0]  direct_addr;

    modport decoder (
        input  opcode, phase,
        output next_step, phase_init, a_src, b_src, alu_op, direct_addr
    );
    modport datapath (output opcode, input a_src, b_src, alu_op, direct_addr);
    modport control (input next_step, phase_init);

endinterface

//--- control/cpu_control.sv
// one-hot instruction state machine, phase and nop counters, registered bus strobes
`timescale 1ns/10ps

module cpu_control import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    decode_if.control          dec,
    output cpu_state_t         state,
    output logic [phase_w-1:0] phase,
    output logic               capture_ins,
    output logic               capture_rom,
    output logic               capture_ram,
    output logic               do_process,
    output logic               read_en,
    output logic               write_en,
    output logic               memory_select
);

    cpu_state_t         state_nxt;
    logic [phase_w-1:0] phase_nxt;
    logic [2:0]         nop_cnt;
    logic [2:0]         nop_cnt_nxt;
    logic               step_done;      // second cycle of a bus access
    logic               step_done_nxt;
    logic               step_end;
    logic               read_en_nxt;
    logic               write_en_nxt;
    logic               memory_select_nxt;

    assign capture_ins = state[get_ins_idx] & step_done;
    assign capture_rom = state[rom_read_idx] & step_done;
    assign capture_ram = state[ram_read_idx] & step_done;
    assign do_process  = state[process_idx];

    assign step_end = do_process |
                      (step_done & (state[rom_read_idx] | state[ram_read_idx] |
                                    state[ram_write_idx]));

    always_comb begin
        state_nxt         = state;
        phase_nxt         = phase;
        nop_cnt_nxt       = nop_cnt;
        step_done_nxt     = 1'b0;
        read_en_nxt       = 1'b0;
        write_en_nxt      = 1'b0;
        memory_select_nxt = memory_select;
        case (1'b1)
            state[nop_wait_idx]: begin
                if (nop_cnt == 3'd0) begin
                    state_nxt   = get_ins;
                    nop_cnt_nxt = nop_duration;
                end else begin
                    nop_cnt_nxt = nop_cnt - 3'd1;
                end
            end
            state[get_ins_idx]: begin
                phase_nxt         = '0;
                memory_select_nxt = 1'b0;
                if (step_done) begin
                    state_nxt = ins_decode;
                end else begin
                    read_en_nxt   = 1'b1;
                    step_done_nxt = 1'b1;
                end
            end
            state[ins_decode_idx]: begin
                if (phase == '0) begin
                    phase_nxt = dec.phase_init; // first decode of this opcode
                end
                case (dec.next_step)
                    to_nop:       state_nxt = nop_wait;
                    to_ram_read:  state_nxt = ram_read;
                    to_rom_read:  state_nxt = rom_read;
                    to_process:   state_nxt = process;
                    to_ram_write: state_nxt = ram_write;
                    default:      state_nxt = get_ins;
                endcase
            end
            state[rom_read_idx], state[ram_read_idx]: begin
                memory_select_nxt = state[ram_read_idx];
                if (!step_done) begin
                    read_en_nxt   = 1'b1;
                    step_done_nxt = 1'b1;
                end
            end
            state[ram_write_idx]: begin
                memory_select_nxt = 1'b1;
                if (!step_done) begin
                    write_en_nxt  = 1'b1;  // visible in the second cycle only
                    step_done_nxt = 1'b1;
                end
            end
            default: ;
        endcase
        if (step_end) begin
            phase_nxt = phase - 4'd1;
            state_nxt = (phase == 4'd1) ? get_ins : ins_decode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= nop_wait;
            phase         <= '0;
            nop_cnt       <= nop_duration;
            step_done     <= 1'b0;
            read_en       <= 1'b0;
            write_en      <= 1'b0;
            memory_select <= 1'b1;
        end else begin
            state         <= state_nxt;
            phase         <= phase_nxt;
            nop_cnt       <= nop_cnt_nxt;
            step_done     <= step_done_nxt;
            read_en       <= read_en_nxt;
            write_en      <= write_en_nxt;
            memory_select <= memory_select_nxt;
        end
    end

endmodule

//--- datapath/alu.sv
// 8-bit alu with add, subtract with borrow, logic ops and carry out
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  alu_op_t           op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  logic              cy_in,
    output logic [data_w-1:0] result,
    output logic              cy_out
);

    logic [data_w:0] sum;  // extra bit holds carry or borrow

    always_comb begin
        sum    = '0;
        result = b;
        cy_out = cy_in;
        case (op)
            alu_add: begin
                sum    = {1'b0, a} + {1'b0, b};
                result = sum[data_w-1:0];
                cy_out = sum[data_w];
            end
            alu_subb: begin
                sum    = {1'b0, a} - {1'b0, b} - {{data_w{1'b0}}, cy_in};
                result = sum[data_w-1:0];
                cy_out = sum[data_w]; // set when a < b + cy
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            default: result = b;
        endcase
    end

endmodule

//--- datapath/cpu_datapath.sv
// accumulator, psw, pc, instruction and data registers with operand muxing and sfr map
`timescale 1ns/10ps

module cpu_datapath import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    decode_if.datapath        dec,
    input  cpu_state_t        state,
    input  logic              capture_ins,
    input  logic              capture_rom,
    input  logic              capture_ram,
    input  logic              do_process,
    input  logic [data_w-1:0] data_in,
    output logic [addr_w-1:0] addr_bus,
    output logic [data_w-1:0] data_out,
    output logic [data_w-1:0] rom_data
);

    logic [data_w-1:0] acc;
    logic              cy;
    logic              p;
    pc_word_t          pc;
    logic [data_w-1:0] ins_reg;
    logic [data_w-1:0] rom_reg;
    logic [data_w-1:0] ram_reg;
    logic [data_w-1:0] psw_byte;
    logic [data_w-1:0] ram_in;
    logic [data_w-1:0] alu_a;
    logic [data_w-1:0] alu_b;
    logic [data_w-1:0] alu_result;
    logic              alu_cy;

    function automatic logic [data_w-1:0] operand(input operand_src_t src);
        case (src)
            src_a:       return acc;
            src_ram_reg: return ram_reg;
            src_rom_reg: return rom_reg;
            src_addr:    return dec.direct_addr;
            src_pch:     return pc.bytes.pch;
            src_pcl:     return pc.bytes.pcl;
            default:     return '0;
        endcase
    endfunction

    assign dec.opcode = ins_reg;
    assign rom_data   = rom_reg;

    always_comb begin
        psw_byte         = '0;
        psw_byte[psw_cy] = cy;
        psw_byte[psw_p]  = p;
        alu_a            = operand(dec.a_src);
        alu_b            = operand(dec.b_src);
        case (dec.direct_addr)
            sfr_acc: ram_in = acc;  // internal value wins over the bus
            sfr_psw: ram_in = psw_byte;
            default: ram_in = data_in;
        endcase
    end

    alu u_alu (
        .op     (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cy_in  (cy),
        .result (alu_result),
        .cy_out (alu_cy)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            cy       <= 1'b0;
            p        <= 1'b0;
            pc.word  <= '0;
            addr_bus <= '0;
        end else begin
            if (state[get_ins_idx] || state[rom_read_idx]) begin
                addr_bus <= pc.word;
            end else if (state[ram_read_idx] || state[ram_write_idx]) begin
                addr_bus <= {8'h00, dec.direct_addr};
            end
            if (capture_rom && dec.a_src == src_pcl) begin
                pc.bytes.pch <= alu_b;   // ljmp target
                pc.bytes.pcl <= data_in;
            end else if (capture_ins || capture_rom) begin
                pc.word <= pc.word + 16'd1;
            end
            if (do_process && dec.a_src == src_a) begin
                acc <= alu_result;
                cy  <= alu_cy;
                p   <= ^alu_result;
            end else if (state[ram_write_idx]) begin
                if (dec.direct_addr == sfr_acc) begin
                    acc <= alu_a;
                    p   <= ^alu_a;
                end else if (dec.direct_addr == sfr_psw) begin
                    cy <= alu_a[psw_cy]; // p always follows a
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture_ins) ins_reg <= data_in;
        if (capture_rom) rom_reg <= data_in;
        if (capture_ram) ram_reg <= ram_in;
        if (state[ram_write_idx]) data_out <= alu_a;
    end

endmodule

//--- flist.f
common/cpu_pkg.sv
common/decode_if.sv
datapath/alu.sv
datapath/cpu_datapath.sv
source/ins_decoder.sv
control/cpu_control.sv
source/cpu_top.sv
testbench/cpu_bus_assert.sv
testbench/tb_cpu.sv

//--- source/cpu_top.sv
// processor top level with control unit, decoder and datapath on plain bus ports
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] data_in,
    output logic [addr_w-1:0] addr_bus,
    output logic [data_w-1:0] data_out,
    output logic              read_en,
    output logic              write_en,
    output logic              memory_select  // 0 rom, 1 ram
);

    decode_if dec_bus ();

    cpu_state_t        state;
    logic              capture_ins;
    logic              capture_rom;
    logic              capture_ram;
    logic              do_process;
    logic [data_w-1:0] rom_data;

    cpu_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec           (dec_bus.control),
        .state         (state),
        .phase         (dec_bus.phase),
        .capture_ins   (capture_ins),
        .capture_rom   (capture_rom),
        .capture_ram   (capture_ram),
        .do_process    (do_process),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select)
    );

    ins_decoder u_decoder (
        .dec      (dec_bus.decoder),
        .rom_data (rom_data)
    );

    cpu_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec_bus.datapath),
        .state       (state),
        .capture_ins (capture_ins),
        .capture_rom (capture_rom),
        .capture_ram (capture_ram),
        .do_process  (do_process),
        .data_in     (data_in),
        .addr_bus    (addr_bus),
        .data_out    (data_out),
        .rom_data    (rom_data)
    );

endmodule

//--- source/ins_decoder.sv
// opcode and phase decoder giving next step, step count, alu op and operand sources
`timescale 1ns/10ps

module ins_decoder import cpu_pkg::*; (
    decode_if.decoder        dec,
    input logic [data_w-1:0] rom_data
);

    logic [phase_w-1:0] step_phase;

    assign dec.direct_addr = rom_data;  // operand byte of the last rom read
    assign step_phase      = (dec.phase == '0) ? dec.phase_init : dec.phase;

    always_comb begin
        case (dec.opcode)
            op_mov_a_dir, op_add_dir: dec.phase_init = 4'd3;
            op_mov_a_imm, op_mov_dir_a, op_add_imm, op_subb_imm,
            op_anl_imm, op_orl_imm, op_xrl_imm, op_ljmp: dec.phase_init = 4'd2;
            default: dec.phase_init = 4'd0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            op_add_imm, op_add_dir: dec.alu_op = alu_add;
            op_subb_imm:            dec.alu_op = alu_subb;
            op_anl_imm:             dec.alu_op = alu_and;
            op_orl_imm:             dec.alu_op = alu_or;
            op_xrl_imm:             dec.alu_op = alu_xor;
            default:                dec.alu_op = alu_pass_b;
        endcase
    end

    always_comb begin
        dec.next_step = to_get_ins;  // unexpected phase ends the instruction
        dec.a_src     = src_a;
        dec.b_src     = src_none;
        case (dec.opcode)
            op_mov_a_imm, op_add_imm, op_subb_imm, op_anl_imm, op_orl_imm, op_xrl_imm: begin
                dec.b_src = src_rom_reg;
                case (step_phase)
                    4'd2:    dec.next_step = to_rom_read;
                    4'd1:    dec.next_step = to_process;
                    default: ;
                endcase
            end
            op_mov_a_dir, op_add_dir: begin
                dec.b_src = src_ram_reg;
                case (step_phase)
                    4'd3:    dec.next_step = to_rom_read;
                    4'd2:    dec.next_step = to_ram_read;
                    4'd1:    dec.next_step = to_process;
                    default: ;
                endcase
            end
            op_mov_dir_a: begin
                case (step_phase)
                    4'd2:    dec.next_step = to_rom_read;
                    4'd1:    dec.next_step = to_ram_write;
                    default: ;
                endcase
            end
            op_ljmp: begin
                dec.b_src = src_rom_reg;  // high target byte
                case (step_phase)
                    4'd2:    dec.next_step = to_rom_read;
                    4'd1: begin
                        dec.next_step = to_rom_read;
                        dec.a_src     = src_pcl;  // low byte goes straight to pc
                    end
                    default: ;
                endcase
            end
            op_nop:  dec.next_step = to_nop;
            default: dec.next_step = to_nop; // undefined opcodes idle like nop
        endcase
    end

endmodule

//--- testbench/cpu_bus_assert.sv
// concurrent checks on the bus read and write strobes
`timescale 1ns/10ps

module cpu_bus_assert (
    input logic clk,
    input logic rst_n,
    input logic read_en,
    input logic write_en,
    input logic memory_select
);

    rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_en && write_en))
        else $error("read_en and write_en are high in the same cycle");

    write_single: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |=> !write_en)
        else $error("write_en stayed high for two cycles");

    write_to_ram: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |-> memory_select)
        else $error("write_en high while memory_select points at rom");

endmodule

//--- testbench/tb_cpu.sv
// testbench with clock, reset, rom and ram models, random program, reference model and checks
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

    typedef enum logic [1:0] {ev_rom_read, ev_ram_read, ev_ram_write} bus_event_t;

    logic              clk;
    logic              rst_n;
    logic [data_w-1:0] data_in;
    logic [addr_w-1:0] addr_bus;
    logic [data_w-1:0] data_out;
    logic              read_en;
    logic              write_en;
    logic              memory_select;

    logic [7:0]  rom [0:65535];
    logic [7:0]  ram [0:255];
    integer      seed = 70469;
    int          cycles = 0;
    int          limit = 200 * 20 + 100;  // instructions times worst cycles, plus margin
    logic [15:0] end_addr;
    bit          done = 1'b0;
    bus_event_t  exp_kind [$];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];

    cpu_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .addr_bus      (addr_bus),
        .data_out      (data_out),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select)
    );

    bind cpu_top cpu_bus_assert u_bus_assert (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles++;

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s actual %h expected %h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [15:0] ins_length(input logic [7:0] op);
        case (op)
            op_mov_a_imm, op_mov_a_dir, op_mov_dir_a, op_add_imm, op_add_dir,
            op_subb_imm, op_anl_imm, op_orl_imm, op_xrl_imm: return 16'd2;
            op_ljmp: return 16'd3;
            default: return 16'd1;  // nop and undefined opcodes
        endcase
    endfunction

    function automatic logic [7:0] direct_operand();
        int r;
        r = $unsigned($random(seed)) % 20;
        if (r < 16) return 8'h30 + 8'(r);
        else if (r < 18) return sfr_acc;
        else return sfr_psw;
    endfunction

    task automatic add_event(input bus_event_t kind, input logic [15:0] addr,
                             input logic [7:0] data);
        exp_kind.push_back(kind);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        logic [7:0]  ops [0:199];
        logic [15:0] start [0:200];
        int          r;
        int          j;
        for (int a = 0; a < 65536; a++) begin
            rom[a] = 8'($random(seed));
        end
        for (int a = 0; a < 256; a++) begin
            ram[a] = 8'(a * 37) ^ 8'h5C;
        end
        start[0] = 16'h0000;
        for (int i = 0; i < 200; i++) begin
            r = $unsigned($random(seed)) % 14;
            case (r)
                0:       ops[i] = op_nop;
                1:       ops[i] = op_mov_a_imm;
                2, 3:    ops[i] = op_mov_a_dir;
                4, 5, 6: ops[i] = op_mov_dir_a;
                7:       ops[i] = op_add_imm;
                8:       ops[i] = op_add_dir;
                9:       ops[i] = op_subb_imm;
                10:      ops[i] = op_anl_imm;
                11:      ops[i] = op_orl_imm;
                12:      ops[i] = op_xrl_imm;
                default: ops[i] = op_ljmp;
            endcase
            if (i == 199) ops[i] = op_ljmp;  // self jump marks the end
            start[i+1] = start[i] + ins_length(ops[i]);
        end
        for (int i = 0; i < 200; i++) begin
            rom[start[i]] = ops[i];
            if (ops[i] == op_ljmp) begin
                j = (i == 199) ? 199 : i + 1 + int'($unsigned($random(seed)) % 4);
                if (j > 199) j = 199;  // forward only, so the program ends
                rom[start[i] + 16'd1] = start[j][15:8];
                rom[start[i] + 16'd2] = start[j][7:0];
            end else if (ops[i] == op_mov_a_dir || ops[i] == op_mov_dir_a ||
                         ops[i] == op_add_dir) begin
                rom[start[i] + 16'd1] = direct_operand();
            end else if (ops[i] != op_nop) begin
                rom[start[i] + 16'd1] = 8'($random(seed));
            end
        end
        end_addr = start[199];
    endtask

    // instruction-level model producing the expected bus events in order
    task automatic run_model();
        logic [7:0]  acc;
        logic        cy;
        logic [15:0] pc;
        logic [15:0] fetch_pc;
        logic [7:0]  op;
        logic [7:0]  arg;
        logic [7:0]  val;
        logic [7:0]  mram [0:255];
        int          sum;
        bit          seen_end;
        acc = 8'h00;
        cy = 1'b0;
        pc = 16'h0000;
        seen_end = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mram[a] = ram[a];
        end
        while (1) begin
            fetch_pc = pc;
            op = rom[pc];
            add_event(ev_rom_read, pc, 8'h00);
            pc = pc + 16'd1;
            if (fetch_pc == end_addr) begin
                if (seen_end) break;
                seen_end = 1'b1;
            end
            if (ins_length(op) == 16'd3) begin
                add_event(ev_rom_read, pc, 8'h00);
                add_event(ev_rom_read, pc + 16'd1, 8'h00);
                pc = {rom[pc], rom[pc + 16'd1]};
            end else if (ins_length(op) == 16'd2) begin
                arg = rom[pc];
                add_event(ev_rom_read, pc, 8'h00);
                pc = pc + 16'd1;
                if (op == op_mov_dir_a) begin
                    add_event(ev_ram_write, {8'h00, arg}, acc);
                    mram[arg] = acc;
                    if (arg == sfr_psw) cy = acc[psw_cy];
                end else begin
                    val = arg;
                    if (op == op_mov_a_dir || op == op_add_dir) begin
                        add_event(ev_ram_read, {8'h00, arg}, 8'h00);
                        if (arg == sfr_acc) val = acc;
                        else if (arg == sfr_psw) val = {cy, 6'b0, ^acc};
                        else val = mram[arg];
                    end
                    case (op)
                        op_add_imm, op_add_dir: begin
                            sum = int'(acc) + int'(val);
                            cy = sum > 255;
                            acc = 8'(sum);
                        end
                        op_subb_imm: begin
                            sum = int'(acc) - int'(val) - int'(cy);
                            cy = sum < 0;  // borrow
                            acc = 8'(sum);
                        end
                        op_anl_imm: acc = acc & val;
                        op_orl_imm: acc = acc | val;
                        op_xrl_imm: acc = acc ^ val;
                        default:    acc = val;  // both mov forms
                    endcase
                end
            end
        end
    endtask

    task automatic observe(input bus_event_t kind, input logic [15:0] addr,
                           input logic [7:0] data);
        check("bus event type", 16'(kind), 16'(exp_kind[0]));
        if (kind == ev_rom_read) check("addr_bus", addr, exp_addr[0]);
        else check("addr_bus[7:0]", {8'h00, addr[7:0]}, {8'h00, exp_addr[0][7:0]});
        if (kind == ev_ram_write) check("data_out", {8'h00, data}, {8'h00, exp_data[0]});
        void'(exp_kind.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        if (exp_kind.size() == 0) done = 1'b1;
    endtask

    // memory models answer and the bus is sampled just after each edge
    always @(posedge clk) begin
        #1;
        if (rst_n && !done) begin
            if (write_en) begin
                ram[addr_bus[7:0]] = data_out;
                observe(ev_ram_write, addr_bus, data_out);
            end
            if (read_en) observe(memory_select ? ev_ram_read : ev_rom_read, addr_bus, 8'h00);
        end
        if (!read_en) data_in = 8'h00;
        else if (memory_select) data_in = ram[addr_bus[7:0]];
        else data_in = rom[addr_bus];
    end

    initial begin
        rst_n = 1'b0;
        data_in = 8'h00;
        build_program();
        run_model();
        repeat (16) @(posedge clk);
        #1;
        check("read_en", {15'b0, read_en}, 16'h0000);
        check("write_en", {15'b0, write_en}, 16'h0000);
        check("memory_select", {15'b0, memory_select}, 16'h0001);
        check("addr_bus", addr_bus, 16'h0000);
        rst_n = 1'b1;
        wait (done || cycles >= limit);
        if (done) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("timeout: the program did not reach its final jump in %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

endmodule
